// File: rtl/aes_cfg.svh
// aes round configuration: state geometry shared by the whole datapath
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// columns per state; the state is square, so also the row count
`define AES_NB 4

// bits per state byte
`define AES_BYTE_W 8

// low byte of the field polynomial x^8 + x^4 + x^3 + x + 1
`define AES_POLY 8'h1b

`endif

// File: rtl/aes_pkg.sv
// aes package: byte, row and state types plus GF(2^8) doubling
`default_nettype none

`include "aes_cfg.svh"

package aes_pkg;

  // one state byte
  typedef logic [`AES_BYTE_W-1:0] byte_t;

  // one state row, element 0 is column 0
  typedef byte_t [`AES_NB-1:0] row_t;

  // full state in aes byte order
  // element k sits at column k/NB, row k%NB; element 0 is the msb byte
  typedef byte_t [0:`AES_NB*`AES_NB-1] state_t;

  // multiply by x in GF(2^8)
  // shift left, fold the carry back in with the reduction polynomial
  function automatic byte_t xtime(input byte_t b);
    byte_t shifted;
    shifted = {b[`AES_BYTE_W-2:0], 1'b0};
    if (b[`AES_BYTE_W-1])
    begin
      shifted = shifted ^ `AES_POLY;
    end
    return shifted;
  endfunction

endpackage

`default_nettype wire

// File: rtl/state_loader.sv
// state loader: input register stage, splits state and key into rows
`timescale 1ns/1ns
`default_nettype none

`include "aes_cfg.svh"

module state_loader (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  aes_pkg::state_t         in_state,
  input  aes_pkg::state_t         in_key,
  output logic                    row_valid,
  input  logic [`AES_NB-1:0]      row_ready,
  output aes_pkg::row_t           row_data [`AES_NB],
  output aes_pkg::row_t           key_data [`AES_NB]
);

  // entry occupied
  logic            full;
  // held state and key, column-major
  aes_pkg::state_t state_q;
  aes_pkg::state_t key_q;
  // all rotators take the rows on the same edge
  logic            row_fire;

  assign row_valid = full;
  assign row_fire  = full & (&row_ready);
  // free, or being drained this cycle
  assign in_ready  = ~full | row_fire;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      full <= 1'b0;
    end
    else if (in_valid && in_ready)
    begin
      full <= 1'b1;
    end
    else if (row_fire)
    begin
      full <= 1'b0;
    end
  end

  // payload only moves on an accepted input
  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
    begin
      state_q <= in_state;
      key_q   <= in_key;
    end
  end

  // transpose: row r, column c comes from byte c*NB + r
  always_comb
  begin
    for (int r = 0; r < `AES_NB; r++)
    begin
      for (int c = 0; c < `AES_NB; c++)
      begin
        row_data[r][c] = state_q[c*`AES_NB + r];
        key_data[r][c] = key_q[c*`AES_NB + r];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/row_rotator.sv
// row rotator: register stage doing the ShiftRows left rotation of one row
`timescale 1ns/1ns
`default_nettype none

`include "aes_cfg.svh"

module row_rotator #(
  // bytes to rotate left, normally the row index
  parameter int ROW = 0
) (
  input  logic          clk,
  input  logic          resetn,
  input  logic          in_valid,
  output logic          in_ready,
  input  aes_pkg::row_t in_row,
  input  aes_pkg::row_t in_key,
  output logic          out_valid,
  input  logic          out_ready,
  output aes_pkg::row_t out_row,
  output aes_pkg::row_t out_key
);

  logic full;

  assign out_valid = full;
  // accept when empty or when the held row leaves this cycle
  assign in_ready  = ~full | out_ready;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      full <= 1'b0;
    end
    else if (in_ready)
    begin
      // load, drain, or both at once
      full <= in_valid;
    end
  end

  // column c takes input column (c + ROW) mod NB
  // key row rides along untouched
  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
    begin
      for (int c = 0; c < `AES_NB; c++)
      begin
        out_row[c] <= in_row[(c + ROW) % `AES_NB];
      end
      out_key <= in_key;
    end
  end

endmodule

`default_nettype wire

// File: rtl/column_mixer.sv
// column mixer: output stage doing MixColumns and AddRoundKey on the rows
`timescale 1ns/1ns
`default_nettype none

`include "aes_cfg.svh"

module column_mixer (
  input  logic                clk,
  input  logic                resetn,
  input  logic [`AES_NB-1:0]  rot_valid,
  output logic                mix_ready,
  input  aes_pkg::row_t       rot_row [`AES_NB],
  input  aes_pkg::row_t       rot_key [`AES_NB],
  output logic                out_valid,
  input  logic                out_ready,
  output aes_pkg::state_t     out_state
);

  // output register occupied
  logic            full;
  // room for a new state this cycle
  logic            space;
  // every rotator is presenting a row
  logic            rows_valid;
  // combinational round result
  aes_pkg::state_t mix_state;

  assign out_valid  = full;
  assign space      = ~full | out_ready;
  assign rows_valid = &rot_valid;
  // shared ready, so no rotator drains unless the whole set is taken
  assign mix_ready  = space & rows_valid;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      full <= 1'b0;
    end
    else if (space)
    begin
      full <= rows_valid;
    end
  end

  // MixColumns as the circulant 2 3 1 1
  // row r of column c:
  //   2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3], indices mod NB
  // 3*a is xtime(a) ^ a
  // key byte for (r, c) is xored straight in
  always_comb
  begin
    for (int c = 0; c < `AES_NB; c++)
    begin
      for (int r = 0; r < `AES_NB; r++)
      begin
        mix_state[c*`AES_NB + r] =
            aes_pkg::xtime(rot_row[r][c])
          ^ aes_pkg::xtime(rot_row[(r + 1) % `AES_NB][c])
          ^ rot_row[(r + 1) % `AES_NB][c]
          ^ rot_row[(r + 2) % `AES_NB][c]
          ^ rot_row[(r + 3) % `AES_NB][c]
          ^ rot_key[r][c];
      end
    end
  end

  // capture on the same edge the rows are taken
  always_ff @(posedge clk)
  begin
    if (mix_ready)
    begin
      out_state <= mix_state;
    end
  end

endmodule

`default_nettype wire

// File: rtl/round_linear_top.sv
// aes round linear top: ShiftRows, MixColumns and AddRoundKey pipeline
`timescale 1ns/1ns
`default_nettype none

`include "aes_cfg.svh"

module round_linear_top (
  input  logic            clk,
  input  logic            resetn,
  input  logic            in_valid,
  output logic            in_ready,
  input  aes_pkg::state_t in_state,
  input  aes_pkg::state_t in_key,
  output logic            out_valid,
  input  logic            out_ready,
  output aes_pkg::state_t out_state
);

  // loader to rotators
  logic                row_valid;
  logic [`AES_NB-1:0]  row_ready;
  aes_pkg::row_t       row_data [`AES_NB];
  aes_pkg::row_t       key_data [`AES_NB];

  // rotators to mixer
  logic [`AES_NB-1:0]  rot_valid;
  logic                mix_ready;
  aes_pkg::row_t       rot_row [`AES_NB];
  aes_pkg::row_t       rot_key [`AES_NB];

  state_loader loader_i (
    .clk       (clk),
    .resetn    (resetn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_state  (in_state),
    .in_key    (in_key),
    .row_valid (row_valid),
    .row_ready (row_ready),
    .row_data  (row_data),
    .key_data  (key_data)
  );

  // one rotator per row, rotation equal to the row index
  // shared valid in and shared ready back keep the four in lockstep
  for (genvar r = 0; r < `AES_NB; r++)
  begin : g_row
    row_rotator #(
      .ROW (r)
    ) rotator_i (
      .clk       (clk),
      .resetn    (resetn),
      .in_valid  (row_valid),
      .in_ready  (row_ready[r]),
      .in_row    (row_data[r]),
      .in_key    (key_data[r]),
      .out_valid (rot_valid[r]),
      .out_ready (mix_ready),
      .out_row   (rot_row[r]),
      .out_key   (rot_key[r])
    );
  end

  column_mixer mixer_i (
    .clk       (clk),
    .resetn    (resetn),
    .rot_valid (rot_valid),
    .mix_ready (mix_ready),
    .rot_row   (rot_row),
    .rot_key   (rot_key),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_state (out_state)
  );

endmodule

`default_nettype wire

// File: sim/round_linear_tb.sv
// round linear testbench: random and known-vector checks of ShiftRows, MixColumns, AddRoundKey
`timescale 1ns/1ns
`default_nettype none

`include "aes_cfg.svh"

module round_linear_tb;

  // phase sizes
  localparam int N_STREAM   = 200;
  localparam int N_STALL    = 200;
  localparam int N_GAP      = 200;
  localparam int N_PRE_RST  = 20;
  localparam int N_POST_RST = 100;
  localparam int N_TOTAL    = 1 + N_STREAM + N_STALL + N_GAP + N_PRE_RST + N_POST_RST;
  localparam int TIMEOUT_CYCLES = 4 * N_TOTAL + 200;
  // cycles allowed for the pipeline to empty
  localparam int DRAIN_LIMIT = 64;
  localparam logic [31:0] SEED = 32'h714a_8fdd;

  // worked example, round 1 after SubBytes, round 1 key, start of round 2
  localparam aes_pkg::state_t KNOWN_IN  = 128'hd42711ae_e0bf98f1_b8b45de5_1e415230;
  localparam aes_pkg::state_t KNOWN_KEY = 128'ha0fafe17_88542cb1_23a33939_2a6c7605;
  localparam aes_pkg::state_t KNOWN_OUT = 128'ha49c7ff2_689f352b_6b5bea43_026a5049;

  logic            clk;
  logic            resetn;
  logic            in_valid;
  logic            in_ready;
  aes_pkg::state_t in_state;
  aes_pkg::state_t in_key;
  logic            out_valid;
  logic            out_ready;
  aes_pkg::state_t out_state;

  // lfsr state shared by every draw
  logic [31:0]     lfsr_q;
  int              cycle;
  // scoreboard of expected results and their input cycles
  aes_pkg::state_t exp_q [$];
  int              t_q [$];
  aes_pkg::state_t last_out;
  logic            check_latency;
  logic            stall_en;
  logic            ready_next;
  logic            saw_in_ready_low;

  round_linear_top dut_i (
    .clk       (clk),
    .resetn    (resetn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_state  (in_state),
    .in_key    (in_key),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_state (out_state)
  );

  always #4 clk = ~clk;

  // taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic rand_bit();
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    return lfsr_q[0];
  endfunction

  function automatic logic [127:0] rand_vec();
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < 128; i++)
    begin
      v = {v[126:0], rand_bit()};
    end
    return v;
  endfunction

  // expected round output written column by column from the standard
  function automatic aes_pkg::state_t round_ref(input aes_pkg::state_t s,
                                                input aes_pkg::state_t k);
    aes_pkg::byte_t  sh [`AES_NB][`AES_NB];
    aes_pkg::byte_t  a0, a1, a2, a3;
    aes_pkg::state_t res;
    // ShiftRows takes row r of column c from column c+r
    for (int c = 0; c < `AES_NB; c++)
    begin
      for (int r = 0; r < `AES_NB; r++)
      begin
        sh[c][r] = s[((c + r) % `AES_NB) * `AES_NB + r];
      end
    end
    for (int c = 0; c < `AES_NB; c++)
    begin
      a0 = sh[c][0];
      a1 = sh[c][1];
      a2 = sh[c][2];
      a3 = sh[c][3];
      res[c*4 + 0] = aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3;
      res[c*4 + 1] = a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3;
      res[c*4 + 2] = a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3;
      res[c*4 + 3] = aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3);
    end
    return res ^ k;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // hold valid and payload until the handshake edge
  task automatic send_state(input aes_pkg::state_t s, input aes_pkg::state_t k);
    in_valid = 1'b1;
    in_state = s;
    in_key   = k;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic run_stream(input int count, input logic gaps);
    aes_pkg::state_t s;
    aes_pkg::state_t k;
    for (int i = 0; i < count; i++)
    begin
      // optional idle cycle before this state
      if (gaps && rand_bit())
      begin
        in_valid = 1'b0;
        @(posedge clk);
        #1;
      end
      s = rand_vec();
      k = rand_vec();
      send_state(s, k);
    end
    in_valid = 1'b0;
  endtask

  // wait until the queue empties or DRAIN_LIMIT cycles pass
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
  endtask

  // out_ready stall pattern drawn half a cycle ahead
  always @(negedge clk)
  begin
    if (stall_en)
      ready_next = rand_bit();
    else
      ready_next = 1'b1;
  end

  always @(posedge clk)
  begin
    #1;
    out_ready = ready_next;
  end

  always @(posedge clk)
  begin
    cycle = cycle + 1;
    if (cycle > TIMEOUT_CYCLES)
      fail_run("timeout: pipeline did not finish within the cycle limit");
  end

  // monitor at the falling edge where every handshake signal is settled
  always @(negedge clk)
  begin
    if (!resetn)
    begin
      exp_q.delete();
      t_q.delete();
    end
    else
    begin
      // pop before push since a state never leaves on its own input edge
      if (out_valid && out_ready)
      begin
        if (exp_q.size() == 0)
          fail_run("output transfer with no matching input");
        check_value("out_state", out_state, exp_q.pop_front());
        if (check_latency)
          check_value("latency", 128'(cycle - t_q[0]), 128'd3);
        void'(t_q.pop_front());
        last_out = out_state;
      end
      if (in_valid && in_ready)
      begin
        exp_q.push_back(round_ref(in_state, in_key));
        t_q.push_back(cycle);
      end
      if (!in_ready)
        saw_in_ready_low = 1'b1;
    end
  end

  initial
  begin
    lfsr_q           = SEED;
    cycle            = 0;
    check_latency    = 1'b0;
    stall_en         = 1'b0;
    ready_next       = 1'b1;
    saw_in_ready_low = 1'b0;
    clk              = 1'b0;
    resetn           = 1'b0;
    in_valid         = 1'b0;
    in_state         = '0;
    in_key           = '0;
    out_ready        = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    resetn = 1'b1;

    // known round from the worked example
    check_value("round_ref", round_ref(KNOWN_IN, KNOWN_KEY), KNOWN_OUT);
    check_latency = 1'b1;
    send_state(KNOWN_IN, KNOWN_KEY);
    in_valid = 1'b0;
    drain();
    check_value("out_state", last_out, KNOWN_OUT);

    // back to back with no stalls and fixed latency
    run_stream(N_STREAM, 1'b0);
    drain();
    check_latency = 1'b0;

    // random out_ready stalls
    stall_en         = 1'b1;
    saw_in_ready_low = 1'b0;
    run_stream(N_STALL, 1'b0);
    drain();
    if (!saw_in_ready_low)
      fail_run("in_ready never dropped under output back-pressure");

    // random input gaps
    stall_en = 1'b0;
    run_stream(N_GAP, 1'b1);
    drain();

    // reset with states still in flight
    stall_en = 1'b1;
    run_stream(N_PRE_RST, 1'b1);
    resetn = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    check_value("out_valid", 128'(out_valid), 128'h0);
    check_value("in_ready", 128'(in_ready), 128'h1);
    @(posedge clk);
    #1;
    resetn = 1'b1;
    run_stream(N_POST_RST, 1'b1);
    drain();

    // idle tail catches stray outputs
    repeat (8) @(posedge clk);
    if (exp_q.size() != 0)
    begin
      $display("expected results still queued at end of run");
      $display("Simulation failed");
      $fatal(1);
    end
    else
    begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/aes_pkg.sv
rtl/state_loader.sv
rtl/row_rotator.sv
rtl/column_mixer.sv
rtl/round_linear_top.sv
sim/round_linear_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= round_linear_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
